/* hw/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int LINE_W = 128;

    // Request and memory operation codes
    typedef enum logic [2:0] {
        NO_OP = 3'd0,
        LD    = 3'd1,
        ST    = 3'd2,
        RD    = 3'd3,
        WR    = 3'd4,
        REPLY = 3'd6
    } op_e;

    // Line fill from memory
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] data;
    } fill_msg_t;

    // Miss read or dirty eviction toward memory
    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] data;
    } mem_req_t;

endpackage

`default_nettype wire

/* hw/dcache_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface dcache_req_if #(
    parameter int CL_SIZE      = dcache_pkg::LINE_W,
    parameter int OOO_TAG_SIZE = 10
) ();

    logic                          valid;
    dcache_pkg::op_e               op;
    logic [dcache_pkg::ADDR_W-1:0] addr;
    logic [CL_SIZE-1:0]            data;
    logic [OOO_TAG_SIZE-1:0]       tag;
    logic                          stall;

    modport arb (output valid, op, addr, data, tag, input stall);
    modport bank (input valid, op, addr, data, tag, output stall);

endinterface

`default_nettype wire

/* hw/msg_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module msg_queue #(
    parameter type payload_t = logic,
    parameter int  Q_LENGTH  = 4
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     alloc,
    input  wire payload_t din,
    output logic          full,
    input  wire logic     dealloc,
    output logic          valid,
    output payload_t      dout
);

    localparam int PTR_W = (Q_LENGTH > 1) ? $clog2(Q_LENGTH) : 1;
    localparam int CNT_W = $clog2(Q_LENGTH + 1);

    payload_t          entries [Q_LENGTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(Q_LENGTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(Q_LENGTH));
    assign valid = (count != '0);
    assign push  = alloc && !full;
    assign pop   = dealloc && valid;
    assign dout  = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

/* hw/queue_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module queue_arbiter #(
    parameter int CL_SIZE      = dcache_pkg::LINE_W,
    parameter int OOO_TAG_SIZE = 10
) (
    input  wire logic                          reply_valid,
    input  wire dcache_pkg::fill_msg_t         reply_msg,
    output logic                               reply_grant,
    input  wire logic                          pipe_valid,
    input  wire dcache_pkg::op_e               pipe_op,
    input  wire logic [dcache_pkg::ADDR_W-1:0] pipe_addr,
    input  wire logic [CL_SIZE-1:0]            pipe_data,
    input  wire logic [OOO_TAG_SIZE-1:0]       pipe_tag,
    output logic                               pipe_grant,
    dcache_req_if.arb                          req
);

    // Fills go first so pending misses can complete
    assign reply_grant = !req.stall && reply_valid;
    assign pipe_grant  = !req.stall && !reply_valid && pipe_valid;
    assign req.valid   = reply_grant || pipe_grant;

    always_comb begin
        if (reply_valid) begin
            req.op   = dcache_pkg::REPLY;
            req.addr = reply_msg.addr;
            req.data = reply_msg.data;
            req.tag  = '0;
        end else begin
            req.op   = pipe_op;
            req.addr = pipe_addr;
            req.data = pipe_data;
            req.tag  = pipe_tag;
        end
    end

endmodule

`default_nettype wire

/* hw/cache_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_bank #(
    parameter int CL_SIZE      = dcache_pkg::LINE_W,
    parameter int IDX_CNT      = 16,
    parameter int OOO_TAG_SIZE = 10
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    dcache_req_if.bank                    req,
    input  wire logic                     mem_q_full,
    output logic                          mem_alloc,
    output dcache_pkg::mem_req_t          mem_req,
    output logic                          resp_valid,
    output logic                          resp_hit,
    output dcache_pkg::op_e               resp_op,
    output logic [dcache_pkg::ADDR_W-1:0] resp_addr,
    output logic [CL_SIZE-1:0]            resp_data,
    output logic [OOO_TAG_SIZE-1:0]       resp_tag
);

    localparam int OFF_W = $clog2(CL_SIZE / 8);
    localparam int IDX_W = $clog2(IDX_CNT);
    localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - OFF_W;

    logic [TAG_W-1:0]   tag_q   [IDX_CNT];
    logic [CL_SIZE-1:0] data_q  [IDX_CNT];
    logic [IDX_CNT-1:0] valid_q;
    logic [IDX_CNT-1:0] dirty_q;

    logic [IDX_W-1:0]              idx;
    logic [TAG_W-1:0]              req_tag;
    logic [CL_SIZE-1:0]            line_rd;
    logic [dcache_pkg::ADDR_W-1:0] line_addr;
    logic [dcache_pkg::ADDR_W-1:0] victim_addr;
    logic                          hit;
    logic                          is_access;
    logic                          is_store;
    logic                          is_reply;
    logic                          victim_dirty;

    assign idx     = req.addr[OFF_W +: IDX_W];
    assign req_tag = req.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign line_rd = data_q[idx];

    assign line_addr   = {req.addr[dcache_pkg::ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign victim_addr = {tag_q[idx], idx, {OFF_W{1'b0}}};

    assign hit          = valid_q[idx] && (tag_q[idx] == req_tag);
    assign is_store     = (req.op == dcache_pkg::ST);
    assign is_access    = (req.op == dcache_pkg::LD) || is_store;
    assign is_reply     = (req.op == dcache_pkg::REPLY);
    assign victim_dirty = valid_q[idx] && dirty_q[idx];

    // Nothing is granted while the memory queue cannot take a push
    assign req.stall = mem_q_full;

    // Miss read or eviction pushed at the acceptance edge
    assign mem_alloc = req.valid &&
                       ((is_access && !hit) || (is_reply && victim_dirty));

    always_comb begin
        if (is_reply) begin
            mem_req.op   = dcache_pkg::WR;
            mem_req.addr = victim_addr;
            mem_req.data = line_rd;
        end else begin
            mem_req.op   = dcache_pkg::RD;
            mem_req.addr = line_addr;
            mem_req.data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req.valid && is_access;
            if (req.valid && is_reply) begin
                // Fill always lands clean
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end else if (req.valid && is_store && hit) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && is_reply) begin
            tag_q[idx]  <= req_tag;
            data_q[idx] <= req.data;
        end else if (req.valid && is_store && hit) begin
            data_q[idx] <= req.data;
        end
    end

    // Response registered one cycle after acceptance
    always_ff @(posedge clk) begin
        if (req.valid && is_access) begin
            resp_hit  <= hit;
            resp_op   <= req.op;
            resp_addr <= req.addr;
            resp_tag  <= req.tag;
            if (!hit) begin
                resp_data <= '0;
            end else if (is_store) begin
                resp_data <= req.data;
            end else begin
                resp_data <= line_rd;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_core.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_core #(
    parameter int CL_SIZE      = dcache_pkg::LINE_W,
    parameter int IDX_CNT      = 16,
    parameter int OOO_TAG_SIZE = 10,
    parameter int Q_LENGTH     = 4
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          reply_alloc,
    input  wire logic [dcache_pkg::ADDR_W-1:0] reply_addr,
    input  wire logic [dcache_pkg::LINE_W-1:0] reply_data,
    output logic                               reply_full,
    input  wire logic                          pipe_valid,
    input  wire dcache_pkg::op_e               pipe_op,
    input  wire logic [dcache_pkg::ADDR_W-1:0] pipe_addr,
    input  wire logic [CL_SIZE-1:0]            pipe_data,
    input  wire logic [OOO_TAG_SIZE-1:0]       pipe_tag,
    output logic                               pipe_grant,
    output logic                               resp_valid,
    output logic                               resp_hit,
    output dcache_pkg::op_e                    resp_op,
    output logic [dcache_pkg::ADDR_W-1:0]      resp_addr,
    output logic [CL_SIZE-1:0]                 resp_data,
    output logic [OOO_TAG_SIZE-1:0]            resp_tag,
    output logic                               mem_valid,
    output dcache_pkg::op_e                    mem_op,
    output logic [dcache_pkg::ADDR_W-1:0]      mem_addr,
    output logic [dcache_pkg::LINE_W-1:0]      mem_data,
    input  wire logic                          mem_deq
);

    dcache_pkg::fill_msg_t reply_in;
    dcache_pkg::fill_msg_t reply_head;
    dcache_pkg::mem_req_t  mem_push;
    dcache_pkg::mem_req_t  mem_head;
    logic                  reply_valid;
    logic                  reply_grant;
    logic                  mem_alloc;
    logic                  mem_q_full;

    dcache_req_if #(.CL_SIZE(CL_SIZE), .OOO_TAG_SIZE(OOO_TAG_SIZE)) req_if ();

    assign reply_in.addr = reply_addr;
    assign reply_in.data = reply_data;

    assign mem_op   = mem_head.op;
    assign mem_addr = mem_head.addr;
    assign mem_data = mem_head.data;

    // Inbound line fills
    msg_queue #(.payload_t(dcache_pkg::fill_msg_t), .Q_LENGTH(Q_LENGTH)) reply_q (
        .clk(clk), .rst_n(rst_n),
        .alloc(reply_alloc), .din(reply_in), .full(reply_full),
        .dealloc(reply_grant), .valid(reply_valid), .dout(reply_head)
    );

    queue_arbiter #(.CL_SIZE(CL_SIZE), .OOO_TAG_SIZE(OOO_TAG_SIZE)) queue_arb (
        .reply_valid(reply_valid), .reply_msg(reply_head), .reply_grant(reply_grant),
        .pipe_valid(pipe_valid), .pipe_op(pipe_op), .pipe_addr(pipe_addr),
        .pipe_data(pipe_data), .pipe_tag(pipe_tag), .pipe_grant(pipe_grant),
        .req(req_if.arb)
    );

    cache_bank #(.CL_SIZE(CL_SIZE), .IDX_CNT(IDX_CNT), .OOO_TAG_SIZE(OOO_TAG_SIZE)) bank (
        .clk(clk), .rst_n(rst_n), .req(req_if.bank),
        .mem_q_full(mem_q_full), .mem_alloc(mem_alloc), .mem_req(mem_push),
        .resp_valid(resp_valid), .resp_hit(resp_hit), .resp_op(resp_op),
        .resp_addr(resp_addr), .resp_data(resp_data), .resp_tag(resp_tag)
    );

    // Outbound reads and evictions
    msg_queue #(.payload_t(dcache_pkg::mem_req_t), .Q_LENGTH(Q_LENGTH)) mem_q (
        .clk(clk), .rst_n(rst_n),
        .alloc(mem_alloc), .din(mem_push), .full(mem_q_full),
        .dealloc(mem_deq), .valid(mem_valid), .dout(mem_head)
    );

endmodule

`default_nettype wire

/* testbench/dcache_core_props.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_core_props (
    input wire logic            clk,
    input wire logic            rst_n,
    input wire logic            reply_alloc,
    input wire logic            reply_full,
    input wire logic            reply_grant,
    input wire logic            reply_valid,
    input wire logic            mem_alloc,
    input wire logic            mem_q_full,
    input wire logic            mem_deq,
    input wire logic            mem_valid,
    input wire logic            req_valid,
    input wire dcache_pkg::op_e req_op,
    input wire logic            req_stall,
    input wire logic            resp_valid
);

    logic is_access;

    assign is_access = (req_op == dcache_pkg::LD) || (req_op == dcache_pkg::ST);

    reply_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        reply_alloc |-> !reply_full) else $error("reply queue written while full");
    mem_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        mem_alloc |-> !mem_q_full) else $error("memory queue written while full");
    reply_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
        reply_grant |-> reply_valid) else $error("reply queue popped while empty");
    mem_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
        mem_deq |-> mem_valid) else $error("memory queue popped while empty");
    resp_after_access: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> $past(req_valid && is_access)) else $error("unexpected response");
    no_grant_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        req_stall |-> !req_valid) else $error("request granted during stall");

endmodule

bind dcache_core dcache_core_props props_i (
    .clk(clk), .rst_n(rst_n),
    .reply_alloc(reply_alloc), .reply_full(reply_full),
    .reply_grant(reply_grant), .reply_valid(reply_valid),
    .mem_alloc(mem_alloc), .mem_q_full(mem_q_full),
    .mem_deq(mem_deq), .mem_valid(mem_valid),
    .req_valid(req_if.valid), .req_op(req_if.op), .req_stall(req_if.stall),
    .resp_valid(resp_valid)
);

`default_nettype wire

/* testbench/dcache_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_core_tb;

    localparam int CL_SIZE  = dcache_pkg::LINE_W;
    localparam int Q_LENGTH = 4;
    localparam int N_OPS    = 300;
    localparam int TIMEOUT  = N_OPS * (10 + Q_LENGTH + 8);

    logic clk = 1'b0;
    logic rst_n, reply_alloc, reply_full, pipe_valid, pipe_grant, resp_valid, resp_hit;
    logic mem_valid, mem_deq;
    logic [31:0] reply_addr, pipe_addr, resp_addr, mem_addr;
    logic [CL_SIZE-1:0] reply_data, pipe_data, resp_data, mem_data;
    logic [9:0] pipe_tag, resp_tag;
    dcache_pkg::op_e pipe_op, resp_op, mem_op;

    // Cache, queue and memory model
    logic                  m_valid [16];
    logic                  m_dirty [16];
    logic [31:0]           m_line  [16];
    logic [CL_SIZE-1:0]    m_data  [16];
    logic [CL_SIZE-1:0]    mem_lines [logic [31:0]];
    dcache_pkg::mem_req_t  mq [$];
    dcache_pkg::fill_msg_t rq [$];
    logic [31:0]           pend_addr [$];
    int                    pend_due [$];
    logic                  resp_due, took, exp_hit;
    dcache_pkg::op_e       exp_op;
    logic [31:0]           exp_addr;
    logic [CL_SIZE-1:0]    exp_data;
    logic [9:0]            exp_tag;
    int                    cycle, issued;

    dcache_core #(.CL_SIZE(CL_SIZE), .IDX_CNT(16), .OOO_TAG_SIZE(10), .Q_LENGTH(Q_LENGTH)) UUT (
        .clk(clk), .rst_n(rst_n), .reply_alloc(reply_alloc), .reply_addr(reply_addr),
        .reply_data(reply_data), .reply_full(reply_full), .pipe_valid(pipe_valid),
        .pipe_op(pipe_op), .pipe_addr(pipe_addr), .pipe_data(pipe_data),
        .pipe_tag(pipe_tag), .pipe_grant(pipe_grant), .resp_valid(resp_valid),
        .resp_hit(resp_hit), .resp_op(resp_op), .resp_addr(resp_addr),
        .resp_data(resp_data), .resp_tag(resp_tag), .mem_valid(mem_valid),
        .mem_op(mem_op), .mem_addr(mem_addr), .mem_data(mem_data), .mem_deq(mem_deq)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [CL_SIZE-1:0] expected,
                               input logic [CL_SIZE-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h got %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Untouched memory returns a pattern built from the line address
    function automatic logic [CL_SIZE-1:0] mem_read(input logic [31:0] addr);
        if (mem_lines.exists(addr)) begin
            return mem_lines[addr];
        end
        return {addr, ~addr, addr ^ 32'h3c5a_96e1, addr[15:0], addr[31:16]};
    endfunction

    task automatic drive_inputs();
        logic hold_deq;
        if (took) begin
            pipe_valid = 1'b0;
        end
        if (!pipe_valid && issued < N_OPS && $urandom_range(3) != 0) begin
            // Two indexes and four tags, so lines keep evicting each other
            pipe_valid = 1'b1;
            pipe_op    = ($urandom_range(1) != 0) ? dcache_pkg::ST : dcache_pkg::LD;
            pipe_addr  = {16'h00c0, 6'd0, 2'($urandom_range(3)),
                          ($urandom_range(1) != 0) ? 4'h3 : 4'ha, 4'($urandom)};
            pipe_data  = {$urandom, $urandom, $urandom, $urandom};
            pipe_tag   = 10'($urandom);
            issued++;
        end
        // Memory stops draining for a while to force back-pressure
        hold_deq = (cycle >= 300) && (cycle < 420);
        mem_deq  = mem_valid && !hold_deq && ($urandom_range(1) != 0);
        reply_alloc = 1'b0;
        if (pend_addr.size() != 0 && pend_due[0] <= cycle && !reply_full) begin
            reply_alloc = 1'b1;
            reply_addr  = pend_addr[0];
            reply_data  = mem_read(pend_addr[0]);
        end
    endtask

    task automatic apply_fill();
        dcache_pkg::fill_msg_t f;
        logic [3:0]            idx;
        f   = rq.pop_front();
        idx = f.addr[7:4];
        if (m_valid[idx] && m_dirty[idx]) begin
            mq.push_back('{op: dcache_pkg::WR, addr: m_line[idx], data: m_data[idx]});
        end
        m_valid[idx] = 1'b1;
        m_dirty[idx] = 1'b0;
        m_line[idx]  = {f.addr[31:4], 4'h0};
        m_data[idx]  = f.data;
    endtask

    task automatic apply_access();
        logic [3:0]  idx;
        logic [31:0] line;
        idx      = pipe_addr[7:4];
        line     = {pipe_addr[31:4], 4'h0};
        exp_hit  = m_valid[idx] && (m_line[idx] == line);
        exp_op   = pipe_op;
        exp_addr = pipe_addr;
        exp_tag  = pipe_tag;
        exp_data = '0;
        if (!exp_hit) begin
            mq.push_back('{op: dcache_pkg::RD, addr: line, data: '0});
        end else if (pipe_op == dcache_pkg::ST) begin
            m_data[idx]  = pipe_data;
            m_dirty[idx] = 1'b1;
            exp_data     = pipe_data;
        end else begin
            exp_data = m_data[idx];
        end
        resp_due = 1'b1;
    endtask

    task automatic check_and_update();
        logic stall;
        stall = (mq.size() == Q_LENGTH);
        check_value("reply_full", rq.size() == Q_LENGTH, reply_full);
        check_value("mem_valid", mq.size() != 0, mem_valid);
        check_value("pipe_grant", pipe_valid && !stall && rq.size() == 0, pipe_grant);
        check_value("resp_valid", resp_due, resp_valid);
        if (resp_due) begin
            check_value("resp_hit", exp_hit, resp_hit);
            check_value("resp_op", exp_op, resp_op);
            check_value("resp_addr", exp_addr, resp_addr);
            check_value("resp_data", exp_data, resp_data);
            check_value("resp_tag", exp_tag, resp_tag);
        end
        resp_due = 1'b0;
        if (mem_valid) begin
            check_value("mem_op", mq[0].op, mem_op);
            check_value("mem_addr", mq[0].addr, mem_addr);
            check_value("mem_data", mq[0].data, mem_data);
        end
        if (mem_deq) begin
            if (mq[0].op == dcache_pkg::RD) begin
                pend_addr.push_back(mq[0].addr);
                pend_due.push_back(cycle + 1 + $urandom_range(9));
            end else begin
                mem_lines[mq[0].addr] = mq[0].data;
            end
            void'(mq.pop_front());
        end
        took = pipe_grant;
        if (!stall && rq.size() != 0) begin
            apply_fill();
        end else if (pipe_grant) begin
            apply_access();
        end
        if (reply_alloc) begin
            rq.push_back('{addr: reply_addr, data: reply_data});
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
    endtask

    initial begin
        int unsigned seed;
        seed = $urandom(32'h76aa);
        rst_n = 1'b0;
        reply_alloc = 1'b0;
        reply_addr = '0;
        reply_data = '0;
        pipe_valid = 1'b0;
        pipe_op = dcache_pkg::NO_OP;
        pipe_addr = '0;
        pipe_data = '0;
        pipe_tag = '0;
        mem_deq = 1'b0;
        resp_due = 1'b0;
        took = 1'b0;
        cycle = 0;
        issued = 0;
        for (int i = 0; i < 16; i++) begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_value("resp_valid", 1'b0, resp_valid);
        check_value("mem_valid", 1'b0, mem_valid);
        check_value("pipe_grant", 1'b0, pipe_grant);
        check_value("reply_full", 1'b0, reply_full);
        while (!(issued == N_OPS && !pipe_valid && !resp_due && mq.size() == 0 &&
                 rq.size() == 0 && pend_addr.size() == 0)) begin
            @(posedge clk);
            #1;
            cycle++;
            if (cycle > TIMEOUT) begin
                $display("Timeout after %0d cycles, %0d operations issued", cycle, issued);
                $display("Finished with errors");
                $fatal(1, "Run did not complete");
            end
            drive_inputs();
            @(negedge clk);
            check_and_update();
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* dcache.f */
hw/dcache_pkg.sv
hw/dcache_req_if.sv
hw/msg_queue.sv
hw/queue_arbiter.sv
hw/cache_bank.sv
hw/dcache_core.sv
testbench/dcache_core_props.sv
testbench/dcache_core_tb.sv
